// ==== tb.f ====
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_control.sv
rtl/ex_wb_reg.sv
rtl/ex_stage.sv
verif/ex_stage_sva.sv
verif/ex_stage_tb.sv

// ==== Makefile ====
TOP := ex_stage_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)
	verilator --lint-only -Wall -f tb.f --top-module ex_stage

clean:
	rm -rf obj_dir

// ==== verif/ex_stage_tb.sv ====
// Table-driven testbench for the execute stage, run as top module with the bind file alongside
`timescale 1ns/1ps

module ex_stage_tb import ex_pkg::*; ();

  localparam int unsigned DATA_W = DATA_W_DEFAULT;
  localparam logic [31:0] SEED = 32'h9f30;

  typedef struct {
    string             name;
    id_ex_t            id;
    logic [DATA_W-1:0] csr_rdata;
    logic              csr_ill;
    logic              kill;
    logic              halt;
    int                stall;
    logic              exp_valid;
    logic [DATA_W-1:0] exp_wdata;
    logic              exp_we;
    logic              exp_illegal;
    logic              exp_bch;
  } test_t;

  logic              clk = 1'b0;
  logic              rst_n;
  id_ex_t            id_ex;
  ctrl_t             ctrl;
  logic [DATA_W-1:0] csr_rdata;
  logic              csr_illegal;
  logic              wb_ready;
  ex_wb_t            ex_wb;
  logic [DATA_W-1:0] rf_wdata;
  logic              branch_decision;
  logic [DATA_W-1:0] branch_target;
  logic              ex_ready;
  logic              ex_valid;

  test_t tbl[$];
  int    errors = 0;
  int    checks = 0;
  int    cycle_cnt = 0;
  int    limit = 0;

  ex_stage #(.DATA_W(DATA_W)) i_ex_stage (
    .clk (clk), .rst_n (rst_n), .id_ex_i (id_ex), .ctrl_i (ctrl),
    .csr_rdata_i (csr_rdata), .csr_illegal_i (csr_illegal), .wb_ready_i (wb_ready),
    .ex_wb_o (ex_wb), .rf_wdata_o (rf_wdata), .branch_decision_o (branch_decision),
    .branch_target_o (branch_target), .ex_ready_o (ex_ready), .ex_valid_o (ex_valid)
  );

  always #10 clk = ~clk;

  // Run limit armed once the table is built
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (limit != 0 && cycle_cnt >= limit) begin
      $display("Run stopped after %0d cycles, the DUT never finished", cycle_cnt);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [DATA_W-1:0] alu_ref(input alu_op_e op, input logic [DATA_W-1:0] a,
                                                input logic [DATA_W-1:0] b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << (b % DATA_W);
      ALU_SRL:  return a >> (b % DATA_W);
      ALU_SLT:  return DATA_W'($signed(a) < $signed(b));
      ALU_SLTU: return DATA_W'(a < b);
      ALU_EQ:   return DATA_W'(a == b);
      ALU_NE:   return DATA_W'(a != b);
      ALU_LT:   return DATA_W'($signed(a) < $signed(b));
      ALU_GE:   return DATA_W'($signed(a) >= $signed(b));
      default:  return '0;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] mul_ref(input mul_op_e op, input logic [DATA_W-1:0] a,
                                                input logic [DATA_W-1:0] b);
    logic signed [2*DATA_W-1:0] sprod;
    logic [2*DATA_W-1:0]        uprod;
    sprod = $signed({{DATA_W{a[DATA_W-1]}}, a}) * $signed({{DATA_W{b[DATA_W-1]}}, b});
    uprod = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
    case (op)
      MUL_HSS: return sprod[2*DATA_W-1:DATA_W];
      MUL_HUU: return uprod[2*DATA_W-1:DATA_W];
      default: return uprod[DATA_W-1:0];
    endcase
  endfunction

  function automatic id_ex_t make_id(input logic alu_en, input alu_op_e aop, input logic mul_en,
                                     input mul_op_e mop, input logic csr_en, input logic branch,
                                     input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    id_ex_t id;
    id = '0;
    id.instr_valid   = 1'b1;
    id.pc            = DATA_W_DEFAULT'(32'h1000 + 4 * tbl.size());
    id.alu_en        = alu_en;
    id.alu_op        = aop;
    id.mul_en        = mul_en;
    id.mul_op        = mop;
    id.csr_en        = csr_en;
    id.branch        = branch;
    // Branches write no register
    id.rf_we         = !branch;
    id.rf_waddr      = REG_ADDR_W'(tbl.size() + 1);
    id.operand_a     = a;
    id.operand_b     = b;
    id.branch_target = id.pc + 'h80;
    return id;
  endfunction

  task automatic add_test(input string name, input id_ex_t id, input logic [DATA_W-1:0] csr_rd,
                          input logic csr_ill, input logic kill, input logic halt,
                          input int stall);
    test_t             t;
    logic              bad_csr;
    logic              cmp;
    logic [DATA_W-1:0] ref_res;
    bad_csr = id.csr_en && csr_ill;
    ref_res = alu_ref(id.alu_op, id.operand_a, id.operand_b);
    cmp = id.alu_op inside {ALU_EQ, ALU_NE, ALU_LT, ALU_GE} && ref_res[0];
    t.name = name;
    t.id = id;
    t.csr_rdata = csr_rd;
    t.csr_ill = csr_ill;
    t.kill = kill;
    t.halt = halt;
    t.stall = stall;
    t.exp_valid = !kill;
    if (id.alu_en) begin
      t.exp_wdata = ref_res;
    end else if (id.mul_en) begin
      t.exp_wdata = mul_ref(id.mul_op, id.operand_a, id.operand_b);
    end else begin
      t.exp_wdata = csr_rd;
    end
    t.exp_we = id.rf_we && !bad_csr;
    t.exp_illegal = id.illegal_insn || bad_csr;
    t.exp_bch = id.branch && id.alu_en && cmp;
    tbl.push_back(t);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checking and stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input string field, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      $display("[FAIL] %s %s: expected %h, actual %h", name, field, exp, act);
      errors++;
    end
  endtask

  task automatic report_problem(input string name, input string what);
    $display("Test %s: %s", name, what);
    errors++;
  endtask

  task automatic run_test(input test_t t);
    ex_wb_t snap;
    int     waited;
    int     errs_before;
    errs_before = errors;
    @(posedge clk);
    id_ex          <= t.id;
    csr_rdata      <= t.csr_rdata;
    csr_illegal    <= t.csr_ill;
    ctrl.kill_ex   <= t.kill;
    ctrl.halt_ex   <= t.halt && t.stall > 0;
    wb_ready       <= !(t.stall > 0 && !t.halt);
    // Stall phase by writeback back-pressure or halt
    for (int s = 0; s < t.stall; s++) begin
      @(negedge clk);
      if (s == 0) begin
        snap = ex_wb;
      end else begin
        assert (ex_wb === snap) else report_problem(t.name, "EX/WB changed during a stall");
      end
      assert (!ex_ready) else report_problem(t.name, "ex_ready went high during a stall");
      if (t.halt) begin
        assert (!ex_valid) else report_problem(t.name, "ex_valid high while halted");
      end
      @(posedge clk);
      if (s == t.stall - 1) begin
        ctrl.halt_ex <= 1'b0;
        wb_ready     <= 1'b1;
      end
    end
    waited = 0;
    @(negedge clk);
    // Last stalled edge leaves EX/WB as it was
    if (t.stall > 0) begin
      assert (ex_wb === snap) else report_problem(t.name, "EX/WB changed during a stall");
    end
    while (!ex_ready) begin
      waited++;
      @(negedge clk);
    end
    check_value(t.name, "branch_target", 64'(t.id.branch_target), 64'(branch_target));
    if (t.id.alu_en && t.id.alu_op inside {ALU_EQ, ALU_NE, ALU_LT, ALU_GE}) begin
      check_value(t.name, "branch_decision", 64'(t.exp_wdata[0]), 64'(branch_decision));
    end
    if (t.id.mul_en && !t.kill) begin
      assert (waited >= DATA_W) else report_problem(t.name, "multiply accepted too early");
    end
    check_value(t.name, "ex_valid", 64'(t.exp_valid), 64'(ex_valid));
    // Forwarded write data at handoff
    if (t.exp_valid) begin
      check_value(t.name, "rf_wdata_o", 64'(t.exp_wdata), 64'(rf_wdata));
    end
    // Acceptance edge, then the stage goes idle
    @(posedge clk);
    id_ex       <= '0;
    ctrl        <= '0;
    csr_illegal <= 1'b0;
    @(negedge clk);
    check_value(t.name, "instr_valid", 64'(t.exp_valid), 64'(ex_wb.instr_valid));
    if (t.exp_valid) begin
      check_value(t.name, "pc", 64'(t.id.pc), 64'(ex_wb.pc));
      check_value(t.name, "rf_we", 64'(t.exp_we), 64'(ex_wb.rf_we));
      check_value(t.name, "illegal_insn", 64'(t.exp_illegal), 64'(ex_wb.illegal_insn));
      check_value(t.name, "bch_taken", 64'(t.exp_bch), 64'(ex_wb.bch_taken));
      if (t.exp_we) check_value(t.name, "rf_wdata", 64'(t.exp_wdata), 64'(ex_wb.rf_wdata));
      if (t.exp_we) check_value(t.name, "rf_waddr", 64'(t.id.rf_waddr), 64'(ex_wb.rf_waddr));
      if (t.id.csr_en) check_value(t.name, "csr_en", 64'(!t.csr_ill), 64'(ex_wb.csr_en));
    end
    $display("%-10s %s", t.name, (errors == errs_before) ? "passed" : "failed");
  endtask

  task automatic build_table();
    logic [DATA_W-1:0] ra;
    logic [DATA_W-1:0] rb;
    add_test("add", make_id(1, ALU_ADD, 0, MUL_LO, 0, 0, 'h1234, 'hffff_0001), 0, 0, 0, 0, 0);
    add_test("sub", make_id(1, ALU_SUB, 0, MUL_LO, 0, 0, 'h10, 'h20), 0, 0, 0, 0, 0);
    add_test("and", make_id(1, ALU_AND, 0, MUL_LO, 0, 0, 'hf0f0_ff00, 'h0ff0_f0f0), 0, 0, 0, 0, 0);
    add_test("or", make_id(1, ALU_OR, 0, MUL_LO, 0, 0, 'hf000_0000, 'h0000_000f), 0, 0, 0, 0, 0);
    add_test("xor", make_id(1, ALU_XOR, 0, MUL_LO, 0, 0, 'haaaa_5555, 'hffff_0000), 0, 0, 0, 0, 0);
    add_test("sll", make_id(1, ALU_SLL, 0, MUL_LO, 0, 0, 'h8000_0003, 'h24), 0, 0, 0, 0, 0);
    add_test("srl", make_id(1, ALU_SRL, 0, MUL_LO, 0, 0, 'h8000_0000, 'h1f), 0, 0, 0, 0, 0);
    add_test("slt", make_id(1, ALU_SLT, 0, MUL_LO, 0, 0, 'hffff_fffe, 'h1), 0, 0, 0, 0, 0);
    add_test("sltu", make_id(1, ALU_SLTU, 0, MUL_LO, 0, 0, 'hffff_fffe, 'h1), 0, 0, 0, 0, 0);
    add_test("beq", make_id(1, ALU_EQ, 0, MUL_LO, 0, 1, 'h55, 'h55), 0, 0, 0, 0, 0);
    add_test("bne", make_id(1, ALU_NE, 0, MUL_LO, 0, 1, 'h55, 'h55), 0, 0, 0, 0, 0);
    add_test("blt", make_id(1, ALU_LT, 0, MUL_LO, 0, 1, 'h8000_0000, 'h7fff_ffff), 0, 0, 0, 0, 0);
    add_test("bge", make_id(1, ALU_GE, 0, MUL_LO, 0, 1, 'h8000_0000, 'h7fff_ffff), 0, 0, 0, 0, 0);
    add_test("eq_nobr", make_id(1, ALU_EQ, 0, MUL_LO, 0, 0, 'h9, 'h9), 0, 0, 0, 0, 0);
    add_test("stall", make_id(1, ALU_ADD, 0, MUL_LO, 0, 0, 'h7, 'h8), 0, 0, 0, 0, 3);
    add_test("csr_rd", make_id(0, ALU_ADD, 0, MUL_LO, 1, 0, 'h0, 'h0), 'hcafe_0001, 0, 0, 0, 0);
    add_test("csr_bad", make_id(0, ALU_ADD, 0, MUL_LO, 1, 0, 'h0, 'h0), 'hdead_0002, 1, 0, 0, 0);
    add_test("mul_edge", make_id(0, ALU_ADD, 1, MUL_LO, 0, 0, 'h8000_0000, 'hffff_ffff),
             0, 0, 0, 0, 0);
    add_test("mulh_edge", make_id(0, ALU_ADD, 1, MUL_HSS, 0, 0, 'h8000_0000, 'h8000_0000),
             0, 0, 0, 0, 0);
    add_test("mulh_neg", make_id(0, ALU_ADD, 1, MUL_HSS, 0, 0, 'hffff_fffd, 'h0000_0007),
             0, 0, 0, 0, 0);
    add_test("mulhu_edge", make_id(0, ALU_ADD, 1, MUL_HUU, 0, 0, 'hffff_ffff, 'hffff_ffff),
             0, 0, 0, 0, 0);
    // Random operands, one per multiply opcode
    for (int i = 0; i < 3; i++) begin
      ra = DATA_W'($urandom());
      rb = DATA_W'($urandom());
      add_test($sformatf("mul_rnd%0d", i), make_id(0, ALU_ADD, 1, mul_op_e'(i), 0, 0, ra, rb),
               0, 0, 0, 0, 0);
    end
    add_test("kill_alu", make_id(1, ALU_ADD, 0, MUL_LO, 0, 0, 'h1, 'h2), 0, 0, 1, 0, 0);
    add_test("kill_mul", make_id(0, ALU_ADD, 1, MUL_LO, 0, 0, 'h3, 'h5), 0, 0, 1, 0, 0);
    add_test("after_kill", make_id(1, ALU_SUB, 0, MUL_LO, 0, 0, 'h100, 'h1), 0, 0, 0, 0, 0);
    add_test("halt", make_id(1, ALU_OR, 0, MUL_LO, 0, 0, 'h30, 'h0c), 0, 0, 0, 1, 2);
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n       = 1'b0;
    id_ex       = '0;
    ctrl        = '0;
    csr_rdata   = '0;
    csr_illegal = 1'b0;
    wb_ready    = 1'b1;
    build_table();
    limit = tbl.size() * (DATA_W + 8) + 20;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    foreach (tbl[i]) begin
      run_test(tbl[i]);
    end
    $display("Tests %0d, checks %0d, errors %0d", tbl.size(), checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== verif/ex_stage_sva.sv ====
// Concurrent timing checks for the execute stage, attached to every ex_stage instance by bind
`timescale 1ns/1ps

module ex_stage_sva import ex_pkg::*; (
  input logic   clk,
  input logic   rst_n,
  input logic   wb_ready_i,
  input logic   ex_ready_i,
  input logic   ex_valid_i,
  input ctrl_t  ctrl_i,
  input ex_wb_t ex_wb_i,
  input id_ex_t id_ex_i,
  input logic   csr_illegal_i
);

  // Back-pressure freezes the EX/WB register
  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (!ex_ready_i && !wb_ready_i) |=> $stable(ex_wb_i))
    else $error("EX/WB register changed while stalled");

  // Control flags cleared while reset is held
  flags_in_reset: assert property (@(posedge clk)
    (!rst_n && $past(!rst_n)) |-> (ex_wb_i.instr_valid == 1'b0 && ex_wb_i.rf_we == 1'b0 &&
                                    ex_wb_i.csr_en == 1'b0 && ex_wb_i.bch_taken == 1'b0))
    else $error("EX/WB control flags set during reset");

  // Halted stage offers nothing to writeback
  no_valid_on_halt: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_i.halt_ex |-> !ex_valid_i)
    else $error("ex_valid high while halted");

  // Illegal CSR access handed to writeback lands without any write enable
  no_write_on_bad_csr: assert property (@(posedge clk) disable iff (!rst_n)
    (id_ex_i.csr_en && csr_illegal_i && ex_valid_i && wb_ready_i) |=>
      (!ex_wb_i.rf_we && !ex_wb_i.csr_en && ex_wb_i.illegal_insn))
    else $error("Illegal CSR access reached EX/WB with rf_we set");

endmodule

bind ex_stage ex_stage_sva u_sva (
  .clk           (clk),
  .rst_n         (rst_n),
  .wb_ready_i    (wb_ready_i),
  .ex_ready_i    (ex_ready_o),
  .ex_valid_i    (ex_valid_o),
  .ctrl_i        (ctrl_i),
  .ex_wb_i       (ex_wb_o),
  .id_ex_i       (id_ex_i),
  .csr_illegal_i (csr_illegal_i)
);

// ==== rtl/ex_stage.sv ====
// Execute stage top level, connecting ALU, multiplier, control and the EX/WB register
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; #(
  parameter int unsigned DATA_W = DATA_W_DEFAULT
) (
  input  logic              clk,
  input  logic              rst_n,
  input  id_ex_t            id_ex_i,
  input  ctrl_t             ctrl_i,
  input  logic [DATA_W-1:0] csr_rdata_i,
  input  logic              csr_illegal_i,
  input  logic              wb_ready_i,
  output ex_wb_t            ex_wb_o,
  output logic [DATA_W-1:0] rf_wdata_o,
  output logic              branch_decision_o,
  output logic [DATA_W-1:0] branch_target_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  // Functional unit results
  logic [DATA_W-1:0] alu_result;
  logic              cmp_result;
  logic [DATA_W-1:0] mul_result;
  logic              mul_ready;
  logic              mul_valid;

  // Control to multiplier and register block
  logic              mul_start;
  logic              mul_abort;
  logic              csr_illegal_q;
  logic              load;
  logic              bubble;

  // Branch outputs straight from decode bundle and compare
  assign branch_decision_o = cmp_result;
  assign branch_target_o   = id_ex_i.branch_target[DATA_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////////////////////////////////////////

  ex_alu #(.DATA_W(DATA_W)) u_alu (
    .operator_i   (id_ex_i.alu_op),
    .operand_a_i  (id_ex_i.operand_a[DATA_W-1:0]),
    .operand_b_i  (id_ex_i.operand_b[DATA_W-1:0]),
    .result_o     (alu_result),
    .cmp_result_o (cmp_result)
  );

  ex_mult #(.DATA_W(DATA_W)) u_mult (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (mul_start),
    .abort_i     (mul_abort),
    .ready_i     (wb_ready_i),
    .operator_i  (id_ex_i.mul_op),
    .op_a_i      (id_ex_i.operand_a[DATA_W-1:0]),
    .op_b_i      (id_ex_i.operand_b[DATA_W-1:0]),
    .mul_ready_o (mul_ready),
    .mul_valid_o (mul_valid),
    .result_o    (mul_result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Control and EX/WB register
  ////////////////////////////////////////////////////////////////////////////

  ex_control #(.DATA_W(DATA_W)) u_control (
    .id_ex_i         (id_ex_i),
    .ctrl_i          (ctrl_i),
    .alu_result_i    (alu_result),
    .mul_result_i    (mul_result),
    .csr_rdata_i     (csr_rdata_i),
    .csr_illegal_i   (csr_illegal_i),
    .mul_ready_i     (mul_ready),
    .mul_valid_i     (mul_valid),
    .wb_ready_i      (wb_ready_i),
    .mul_start_o     (mul_start),
    .mul_abort_o     (mul_abort),
    .rf_wdata_o      (rf_wdata_o),
    .csr_illegal_q_o (csr_illegal_q),
    .ex_valid_o      (ex_valid_o),
    .ex_ready_o      (ex_ready_o),
    .load_o          (load),
    .bubble_o        (bubble)
  );

  ex_wb_reg #(.DATA_W(DATA_W)) u_wb_reg (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_i        (load),
    .bubble_i      (bubble),
    .id_ex_i       (id_ex_i),
    .rf_wdata_i    (rf_wdata_o),
    .csr_illegal_i (csr_illegal_q),
    .cmp_result_i  (cmp_result),
    .ex_wb_o       (ex_wb_o)
  );

endmodule

// ==== rtl/ex_wb_reg.sv ====
// EX/WB pipeline register, loaded on handoff to writeback and turned into a bubble otherwise
`timescale 1ns/1ps

module ex_wb_reg import ex_pkg::*; #(
  parameter int unsigned DATA_W = DATA_W_DEFAULT
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              load_i,
  input  logic              bubble_i,
  input  id_ex_t            id_ex_i,
  input  logic [DATA_W-1:0] rf_wdata_i,
  input  logic              csr_illegal_i,
  input  logic              cmp_result_i,
  output ex_wb_t            ex_wb_o
);

  // Control flags
  logic instr_valid_q;
  logic rf_we_q;
  logic illegal_q;
  logic bch_taken_q;
  logic csr_en_q;

  // Payload
  logic [DATA_W_DEFAULT-1:0] pc_q;
  logic [REG_ADDR_W-1:0]     rf_waddr_q;
  logic [DATA_W_DEFAULT-1:0] rf_wdata_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_q <= 1'b0;
      rf_we_q       <= 1'b0;
      illegal_q     <= 1'b0;
      bch_taken_q   <= 1'b0;
      csr_en_q      <= 1'b0;
    end else if (load_i) begin
      instr_valid_q <= 1'b1;
      // Illegal CSR access must not write the register file or CSRs
      rf_we_q       <= csr_illegal_i ? 1'b0 : id_ex_i.rf_we;
      csr_en_q      <= csr_illegal_i ? 1'b0 : id_ex_i.csr_en;
      illegal_q     <= id_ex_i.illegal_insn || csr_illegal_i;
      bch_taken_q   <= id_ex_i.branch && id_ex_i.alu_en && cmp_result_i;
    end else if (bubble_i) begin
      // WB ready with nothing to hand over
      instr_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_i) begin
      pc_q <= id_ex_i.pc;
      // Destination and data only for writing instructions
      if (id_ex_i.rf_we) begin
        rf_waddr_q <= id_ex_i.rf_waddr;
        rf_wdata_q <= DATA_W_DEFAULT'(rf_wdata_i);
      end
    end
  end

  always_comb begin
    ex_wb_o.instr_valid  = instr_valid_q;
    ex_wb_o.pc           = pc_q;
    ex_wb_o.rf_we        = rf_we_q;
    ex_wb_o.rf_waddr     = rf_waddr_q;
    ex_wb_o.rf_wdata     = rf_wdata_q;
    ex_wb_o.illegal_insn = illegal_q;
    ex_wb_o.bch_taken    = bch_taken_q;
    ex_wb_o.csr_en       = csr_en_q;
  end

endmodule

// ==== rtl/ex_control.sv ====
// Execute stage control, gating kill and halt, selecting write data and forming ready and valid
`timescale 1ns/1ps

module ex_control import ex_pkg::*; #(
  parameter int unsigned DATA_W = DATA_W_DEFAULT
) (
  input  id_ex_t            id_ex_i,
  input  ctrl_t             ctrl_i,
  input  logic [DATA_W-1:0] alu_result_i,
  input  logic [DATA_W-1:0] mul_result_i,
  input  logic [DATA_W-1:0] csr_rdata_i,
  input  logic              csr_illegal_i,
  input  logic              mul_ready_i,
  input  logic              mul_valid_i,
  input  logic              wb_ready_i,
  output logic              mul_start_o,
  output logic              mul_abort_o,
  output logic [DATA_W-1:0] rf_wdata_o,
  output logic              csr_illegal_q_o,
  output logic              ex_valid_o,
  output logic              ex_ready_o,
  output logic              load_o,
  output logic              bubble_o
);

  logic instr_valid;

  // Instruction counts only when neither killed nor halted
  assign instr_valid = id_ex_i.instr_valid && !ctrl_i.kill_ex && !ctrl_i.halt_ex;

  // Multiplier starts only for a live instruction
  assign mul_start_o = id_ex_i.mul_en && instr_valid;
  assign mul_abort_o = ctrl_i.kill_ex || ctrl_i.halt_ex;

  // Illegal CSR access of a live instruction
  assign csr_illegal_q_o = id_ex_i.csr_en && csr_illegal_i && instr_valid;

  // Write data mux
  always_comb begin
    if (id_ex_i.alu_en) begin
      rf_wdata_o = alu_result_i;
    end else if (id_ex_i.mul_en) begin
      rf_wdata_o = mul_result_i;
    end else if (id_ex_i.csr_en) begin
      rf_wdata_o = csr_rdata_i;
    end else begin
      rf_wdata_o = alu_result_i;
    end
  end

  // ALU and CSR are single cycle, so always valid
  // Illegal instruction from decode passes to WB as valid
  assign ex_valid_o = (id_ex_i.alu_en || id_ex_i.csr_en || (id_ex_i.mul_en && mul_valid_i) ||
                       id_ex_i.illegal_insn) && instr_valid;

  // Kill frees the stage at once
  assign ex_ready_o = ctrl_i.kill_ex || (mul_ready_i && wb_ready_i && !ctrl_i.halt_ex);

  // EX/WB register steering
  assign load_o   = ex_valid_o && wb_ready_i;
  assign bubble_o = wb_ready_i && !ex_valid_o;

endmodule

// ==== rtl/ex_mult.sv ====
// Iterative shift-add multiplier for MUL, MULH and MULHU, one product bit per cycle
`timescale 1ns/1ps

module ex_mult import ex_pkg::*; #(
  parameter int unsigned DATA_W = DATA_W_DEFAULT
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  logic              abort_i,
  input  logic              ready_i,
  input  mul_op_e           operator_i,
  input  logic [DATA_W-1:0] op_a_i,
  input  logic [DATA_W-1:0] op_b_i,
  output logic              mul_ready_o,
  output logic              mul_valid_o,
  output logic [DATA_W-1:0] result_o
);

  localparam int unsigned CNT_W = $clog2(DATA_W);

  typedef enum logic [1:0] {IDLE, BUSY, DONE} mult_state_e;

  mult_state_e         state_q;
  logic [CNT_W-1:0]    cnt_q;
  logic [2*DATA_W-1:0] acc_q;
  logic [DATA_W-1:0]   mcand_q;
  logic                neg_q;
  logic                hi_q;
  logic                a_neg;
  logic                b_neg;
  logic [DATA_W-1:0]   a_mag;
  logic [DATA_W-1:0]   b_mag;
  logic [DATA_W:0]     partial;
  logic [2*DATA_W-1:0] product;

  // Signed high multiply runs on magnitudes
  assign a_neg = (operator_i == MUL_HSS) && op_a_i[DATA_W-1];
  assign b_neg = (operator_i == MUL_HSS) && op_b_i[DATA_W-1];
  assign a_mag = a_neg ? -op_a_i : op_a_i;
  assign b_mag = b_neg ? -op_b_i : op_b_i;

  // Add multiplicand into upper half when the current multiplier bit is set
  assign partial = {1'b0, acc_q[2*DATA_W-1:DATA_W]} + (acc_q[0] ? {1'b0, mcand_q} : '0);

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else if (abort_i) begin
      // Kill or halt drops any operation in flight
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= BUSY;
            cnt_q   <= '0;
          end
        end
        BUSY: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == CNT_W'(DATA_W - 1)) begin
            state_q <= DONE;
          end
        end
        DONE: begin
          // Hold result until writeback takes it
          if (ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (state_q == IDLE && start_i) begin
      mcand_q <= a_mag;
      acc_q   <= {{DATA_W{1'b0}}, b_mag};
      neg_q   <= a_neg ^ b_neg;
      hi_q    <= (operator_i != MUL_LO);
    end else if (state_q == BUSY) begin
      acc_q <= {partial, acc_q[DATA_W-1:1]};
    end
  end

  // Restore sign of the full product
  assign product  = neg_q ? -acc_q : acc_q;
  assign result_o = hi_q ? product[2*DATA_W-1:DATA_W] : product[DATA_W-1:0];

  // Ready when idle with nothing to start, or when the finished result is taken
  assign mul_ready_o = (state_q == IDLE && !start_i) || (state_q == DONE && ready_i);
  assign mul_valid_o = (state_q == DONE);

endmodule

// ==== rtl/ex_alu.sv ====
// Single-cycle ALU for the execute stage, giving the data result and the branch compare flag
`timescale 1ns/1ps

module ex_alu import ex_pkg::*; #(
  parameter int unsigned DATA_W = DATA_W_DEFAULT
) (
  input  alu_op_e           operator_i,
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,
  output logic [DATA_W-1:0] result_o,
  output logic              cmp_result_o
);

  localparam int unsigned SHAMT_W = $clog2(DATA_W);

  logic              sub;
  logic [DATA_W-1:0] adder_b;
  logic [DATA_W:0]   sum_ext;
  logic              is_eq;
  logic              lt_s;
  logic              lt_u;
  logic [SHAMT_W-1:0] shamt;

  // One adder serves add, subtract and every compare
  assign sub = operator_i inside {ALU_SUB, ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE};
  assign adder_b = sub ? ~operand_b_i : operand_b_i;
  assign sum_ext = {1'b0, operand_a_i} + {1'b0, adder_b} + (DATA_W + 1)'(sub);

  // No carry out of a - b means a borrow
  assign lt_u  = !sum_ext[DATA_W];
  // Signs differ so a is less when a is negative
  assign lt_s  = (operand_a_i[DATA_W-1] ^ operand_b_i[DATA_W-1]) ? operand_a_i[DATA_W-1]
                                                                 : sum_ext[DATA_W-1];
  assign is_eq = (sum_ext[DATA_W-1:0] == '0);

  assign shamt = operand_b_i[SHAMT_W-1:0];

  // Branch compares only
  always_comb begin
    unique case (operator_i)
      ALU_EQ:  cmp_result_o = is_eq;
      ALU_NE:  cmp_result_o = !is_eq;
      ALU_LT:  cmp_result_o = lt_s;
      ALU_GE:  cmp_result_o = !lt_s;
      default: cmp_result_o = 1'b0;
    endcase
  end

  // Result mux
  always_comb begin
    unique case (operator_i)
      ALU_ADD,
      ALU_SUB:  result_o = sum_ext[DATA_W-1:0];
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:  result_o = operand_a_i << shamt;
      ALU_SRL:  result_o = operand_a_i >> shamt;
      // Set-less-than as 0 or 1
      ALU_SLT:  result_o = DATA_W'(lt_s);
      ALU_SLTU: result_o = DATA_W'(lt_u);
      ALU_EQ,
      ALU_NE,
      ALU_LT,
      ALU_GE:   result_o = DATA_W'(cmp_result_o);
      default:  result_o = '0;
    endcase
  end

endmodule

// ==== rtl/ex_pkg.sv ====
// Shared widths, opcode enums and pipeline bundles for the execute stage, imported by RTL and testbench
package ex_pkg;

  // Default operand width, also the size of the pipeline data fields
  localparam int unsigned DATA_W_DEFAULT = 32;

  // Register index width fixed by the ISA
  localparam int unsigned REG_ADDR_W = 5;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SLT  = 4'd7,
    ALU_SLTU = 4'd8,
    // Branch compares
    ALU_EQ   = 4'd9,
    ALU_NE   = 4'd10,
    ALU_LT   = 4'd11,
    ALU_GE   = 4'd12
  } alu_op_e;

  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,
    MUL_HSS = 2'd1,
    MUL_HUU = 2'd2
  } mul_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline bundles
  ////////////////////////////////////////////////////////////////////////////

  // Decode to execute
  typedef struct packed {
    logic                      instr_valid;
    logic [DATA_W_DEFAULT-1:0] pc;
    logic                      alu_en;
    alu_op_e                   alu_op;
    logic                      mul_en;
    mul_op_e                   mul_op;
    logic                      csr_en;
    logic                      branch;
    logic                      rf_we;
    logic [REG_ADDR_W-1:0]     rf_waddr;
    logic                      illegal_insn;
    logic [DATA_W_DEFAULT-1:0] operand_a;
    logic [DATA_W_DEFAULT-1:0] operand_b;
    logic [DATA_W_DEFAULT-1:0] branch_target;
  } id_ex_t;

  // Controller requests to EX
  typedef struct packed {
    logic kill_ex;
    logic halt_ex;
  } ctrl_t;

  // Execute to writeback
  typedef struct packed {
    logic                      instr_valid;
    logic [DATA_W_DEFAULT-1:0] pc;
    logic                      rf_we;
    logic [REG_ADDR_W-1:0]     rf_waddr;
    logic [DATA_W_DEFAULT-1:0] rf_wdata;
    logic                      illegal_insn;
    logic                      bch_taken;
    logic                      csr_en;
  } ex_wb_t;

endpackage
